/* verilog/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t; // Data and address word

	localparam int ALU_OP_W = 4; // ALU operation code width

	// Same 32-bit word seen as R, I or J format
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} i;
		struct packed {
			logic [5:0] op;
			logic [25:0] target26;
		} j;
	} instr_t;

	typedef struct packed {
		logic reg_write; // Register file write
		logic reg_dst_rd; // Destination rd, else rt
		logic link; // Write PC+4 to $31 or rd
		logic alu_src_imm; // ALU B from immediate
		logic zero_ext_imm; // Zero extend, else sign extend
		logic lui; // Immediate into upper half
		logic mem_read; // Load word
		logic mem_write; // Store word
		logic mem_to_reg; // Write back load data
		logic branch_eq; // BEQ
		logic branch_ne; // BNE
		logic jump; // J and JAL
		logic jump_reg; // JR
		logic [ALU_OP_W-1:0] alu_op;
	} ctrl_t;

	// ALU codes, zero is ADDU so a cleared struct adds
	localparam logic [ALU_OP_W-1:0] ALU_ADDU = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUBU = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd5; // Signed compare
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd6; // Unsigned compare
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd9;

endpackage

`default_nettype wire

/* verilog/mips_control.sv */
`default_nettype none

module mips_control (
	input mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t ctrl,
	output logic halt
);
	import mips_pkg::*;

	localparam logic [5:0] OP_SPECIAL = 6'h00; // R-type, decoded by funct
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	logic [ALU_OP_W-1:0] funct_op; // ALU code from funct
	logic funct_ok; // Funct is a kept ALU op

	always_comb begin
		funct_ok = 1'b1;
		funct_op = ALU_ADDU;
		case (instr.r.funct)
			FN_SLL: funct_op = ALU_SLL;
			FN_SRL: funct_op = ALU_SRL;
			FN_SRA: funct_op = ALU_SRA;
			FN_ADDU: funct_op = ALU_ADDU;
			FN_SUBU: funct_op = ALU_SUBU;
			FN_AND: funct_op = ALU_AND;
			FN_OR: funct_op = ALU_OR;
			FN_XOR: funct_op = ALU_XOR;
			FN_SLT: funct_op = ALU_SLT;
			FN_SLTU: funct_op = ALU_SLTU;
			default: funct_ok = 1'b0; // JR and unknown funct
		endcase
	end

	always_comb begin
		ctrl = '0; // Unknown opcode is a no-op
		halt = 1'b0;
		case (instr.r.op)
			OP_SPECIAL: begin
				if (funct_ok) begin
					ctrl.reg_write = 1'b1;
					ctrl.reg_dst_rd = 1'b1;
					ctrl.alu_op = funct_op;
				end else if (instr.r.funct == FN_JR) begin
					ctrl.jump_reg = 1'b1;
					halt = (instr.r.rs == 5'd0); // JR $0 stops the core
				end
			end
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1; // Return address into $31
				ctrl.reg_write = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op = ALU_SUBU; // Zero flag on rs == rt
			end
			OP_BNE: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = ALU_SUBU;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.zero_ext_imm = instr.i.op inside {OP_ANDI, OP_ORI, OP_XORI};
				case (instr.i.op)
					OP_SLTI: ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU; // Sign-extended, unsigned compare
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI: ctrl.alu_op = ALU_OR;
					OP_XORI: ctrl.alu_op = ALU_XOR;
					default: ctrl.alu_op = ALU_ADDU;
				endcase
			end
			OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.lui = 1'b1; // Built in write-back mux
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			default: ;
		endcase
	end

	// No opcode may load and store at once
	always_comb begin
		assert (!(ctrl.mem_read && ctrl.mem_write));
	end

endmodule

`default_nettype wire

/* verilog/mips_pc.sv */
`default_nettype none

module mips_pc #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input logic active,
	input logic halt,
	input mips_pkg::ctrl_t ctrl,
	input logic zero,
	input mips_pkg::instr_t instr,
	input mips_pkg::word_t rs_value,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4,
	output logic active_next
);
	import mips_pkg::*;

	word_t branch_target;
	word_t jump_target;
	word_t pc_next;
	logic taken; // Branch condition met
	logic step; // Enabled edge while running

	assign step = clk_enable & active;
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign jump_target = {pc_plus4[31:28], instr.j.target26, 2'b00}; // Same 256 MB region
	assign taken = (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

	always_comb begin
		if (ctrl.jump_reg)
			pc_next = rs_value; // JR $0 lands on 0
		else if (ctrl.jump)
			pc_next = jump_target;
		else if (taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	// Run flag, fed back through the top as active
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pc <= RESET_VECTOR;
			active_next <= 1'b1;
		end else if (step) begin
			pc <= pc_next;
			if (halt)
				active_next <= 1'b0; // Sticky until reset
		end
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/mips_regfile.sv */
`default_nettype none

module mips_regfile (
	input logic clk,
	input logic reset,
	input logic write_en,
	input logic [4:0] read_addr1,
	input logic [4:0] read_addr2,
	input logic [4:0] write_addr,
	input mips_pkg::word_t write_data,
	output mips_pkg::word_t read_data1,
	output mips_pkg::word_t read_data2,
	output mips_pkg::word_t register_v0
);
	import mips_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en && write_addr != 5'd0) begin
			regs[write_addr] <= write_data; // $0 stays zero
		end
	end

	assign read_data1 = regs[read_addr1]; // Combinational reads
	assign read_data2 = regs[read_addr2];
	assign register_v0 = regs[2]; // Debug tap on $2

	// Decode upstream must give a clean address on every write
	assert property (@(posedge clk) disable iff (reset)
		write_en |-> !$isunknown(write_addr));

endmodule

`default_nettype wire

/* verilog/mips_alu.sv */
`default_nettype none

module mips_alu (
	input logic [mips_pkg::ALU_OP_W-1:0] alu_op,
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	input logic [4:0] shamt,
	output mips_pkg::word_t result,
	output logic zero
);
	import mips_pkg::*;

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			ALU_ADDU:
				result = a + b; // No overflow trap
			ALU_SUBU:
				result = a - b;
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			ALU_SLT:
				result = {31'd0, lt_signed};
			ALU_SLTU:
				result = {31'd0, lt_unsigned};
			ALU_SLL:
				result = b << shamt; // Shifts act on rt
			ALU_SRL:
				result = b >> shamt;
			ALU_SRA:
				result = word_t'($signed(b) >>> shamt); // Keep sign bit
			default:
				result = '0;
		endcase
	end

	assign zero = (result == '0); // Used by BEQ and BNE

endmodule

`default_nettype wire

/* verilog/mips_cpu_harvard.sv */
`default_nettype none

module mips_cpu_harvard #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
	input logic clk,
	input logic reset,
	output logic active,
	output mips_pkg::word_t register_v0,
	input logic clk_enable,
	output mips_pkg::word_t instr_address,
	input mips_pkg::word_t instr_readdata,
	output mips_pkg::word_t data_address,
	output logic data_write,
	output logic data_read,
	output mips_pkg::word_t data_writedata,
	input mips_pkg::word_t data_readdata
);
	import mips_pkg::*;

	instr_t instr;
	ctrl_t ctrl;
	logic halt;
	logic zero;
	logic step; // Instruction retires this edge
	logic [4:0] write_addr;
	word_t write_data;
	word_t rs_value;
	word_t rt_value;
	word_t alu_b;
	word_t alu_result;
	word_t imm_ext;
	word_t pc_plus4;

	assign instr = instr_t'(instr_readdata);
	assign step = clk_enable & active;

	mips_control u_control (
		.instr(instr),
		.ctrl(ctrl),
		.halt(halt)
	);

	mips_pc #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_pc (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.active(active),
		.halt(halt),
		.ctrl(ctrl),
		.zero(zero),
		.instr(instr),
		.rs_value(rs_value),
		.pc(instr_address),
		.pc_plus4(pc_plus4),
		.active_next(active)
	);

	// Destination is $31 for JAL, rd for R-type, else rt
	always_comb begin
		if (ctrl.link && !ctrl.reg_dst_rd)
			write_addr = 5'd31;
		else if (ctrl.reg_dst_rd)
			write_addr = instr.r.rd;
		else
			write_addr = instr.r.rt;
	end

	always_comb begin
		if (ctrl.link)
			write_data = pc_plus4; // Return address
		else if (ctrl.lui)
			write_data = {instr.i.imm16, 16'h0000};
		else if (ctrl.mem_to_reg)
			write_data = data_readdata;
		else
			write_data = alu_result;
	end

	mips_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.write_en(ctrl.reg_write & step),
		.read_addr1(instr.r.rs),
		.read_addr2(instr.r.rt),
		.write_addr(write_addr),
		.write_data(write_data),
		.read_data1(rs_value),
		.read_data2(rt_value),
		.register_v0(register_v0)
	);

	assign imm_ext = ctrl.zero_ext_imm ? {16'h0000, instr.i.imm16}
		: {{16{instr.i.imm16[15]}}, instr.i.imm16};
	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_value;

	mips_alu u_alu (
		.alu_op(ctrl.alu_op),
		.a(rs_value),
		.b(alu_b),
		.shamt(instr.r.shamt),
		.result(alu_result),
		.zero(zero)
	);

	assign data_address = alu_result; // Base plus offset
	assign data_writedata = rt_value;
	assign data_read = ctrl.mem_read & step; // One pulse per executed load
	assign data_write = ctrl.mem_write & step;

endmodule

`default_nettype wire

/* bench/tb_mips_mem.sv */
`default_nettype none

module tb_mips_mem #(
	parameter mips_pkg::word_t INSTR_BASE = 32'hBFC00000,
	parameter int INSTR_WORDS = 64,
	parameter int DATA_WORDS = 256
) (
	input logic clk,
	input mips_pkg::word_t instr_address,
	output mips_pkg::word_t instr_readdata,
	input mips_pkg::word_t data_address,
	input logic data_write,
	input logic data_read,
	input mips_pkg::word_t data_writedata,
	output mips_pkg::word_t data_readdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam int IA_W = $clog2(INSTR_WORDS); // Program word index bits
	localparam int DA_W = $clog2(DATA_WORDS);

	word_t imem [INSTR_WORDS];
	word_t dmem [DATA_WORDS];
	word_t fetch_offset; // Byte offset from program base

	assign fetch_offset = instr_address - INSTR_BASE;

	always_comb begin
		if (fetch_offset < word_t'(INSTR_WORDS * 4))
			instr_readdata = imem[fetch_offset[IA_W+1:2]];
		else
			instr_readdata = '0; // Unmapped fetch is SLL $0 NOP
	end

	assign data_readdata = data_read ? dmem[data_address[DA_W+1:2]] : '0; // Same-cycle read

	always @(posedge clk) begin
		if (data_write)
			dmem[data_address[DA_W+1:2]] <= data_writedata; // Word stores only
	end

	// Empty program, data words seeded from their own address
	task automatic clear_memories();
		word_t addr;
		for (int i = 0; i < INSTR_WORDS; i++)
			imem[i] = '0;
		for (int i = 0; i < DATA_WORDS; i++) begin
			addr = word_t'(i) << 2;
			dmem[i] <= ~addr ^ {addr[15:0], addr[31:16]}; // Byte address mixed with its halves
		end
	endtask

	task automatic load_instr(int index, word_t value);
		imem[index] = value;
	endtask

endmodule

`default_nettype wire

/* bench/tb_mips_cpu.sv */
`default_nettype none

module tb_mips_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam word_t RESET_VECTOR = 32'hBFC00000;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int RUN_BUDGET = 32; // Cycles allowed per program
	localparam int ALU_CASES = 17;
	localparam int PAUSE_LEN = 5;
	localparam int HALT_HOLD = 5;
	localparam int RUNS = ALU_CASES + 5; // Programs run in total
	localparam int WATCHDOG_CYCLES =
		(RUNS + 1) * (RESET_CYCLES + RUN_BUDGET + 2) + PAUSE_LEN + HALT_HOLD + 100;
	localparam word_t SEED = 32'h2dd9;
	localparam word_t DATA_BASE = 32'h00000100;

	// MIPS-I opcodes and funct codes
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	logic data_write;
	logic data_read;
	word_t data_writedata;
	word_t data_readdata;

	word_t prog[$]; // Program under construction
	word_t rng_state;
	word_t stored_value; // Word used by the store tests
	int value_errors = 0;
	int other_errors = 0;
	int check_count = 0;
	int write_count; // Strobes seen during last run
	int read_count;
	word_t last_write_addr;
	word_t last_write_data;

	mips_cpu_harvard #(
		.RESET_VECTOR(RESET_VECTOR)
	) DUT (
		.clk(clk),
		.reset(reset),
		.active(active),
		.register_v0(register_v0),
		.clk_enable(clk_enable),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	tb_mips_mem #(
		.INSTR_BASE(RESET_VECTOR)
	) MEM (
		.clk(clk),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	function automatic word_t xorshift(word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic word_t next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic word_t rtype_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [4:0] shamt, logic [5:0] funct);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t itype_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Jump to program word idx, same 256 MB region as the base
	function automatic word_t jump_word(logic [5:0] op, int idx);
		word_t target;
		target = RESET_VECTOR + word_t'(idx) * 4;
		return {op, target[27:2]};
	endfunction

	task automatic check_word(string name, word_t actual, word_t expected);
		check_count++;
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(string name, logic actual, logic expected);
		check_count++;
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// LUI then ORI builds any 32-bit constant
	task automatic load_const(logic [4:0] rt, word_t value);
		prog.push_back(itype_word(OP_LUI, 5'd0, rt, value[31:16]));
		prog.push_back(itype_word(OP_ORI, rt, rt, value[15:0]));
	endtask

	task automatic check_reset_state();
		check_word("instr_address", instr_address, RESET_VECTOR);
		check_bit("active", active, 1'b1);
		check_bit("data_read", data_read, 1'b0);
		check_bit("data_write", data_write, 1'b0);
		check_word("register_v0", register_v0, '0);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		clk_enable = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#2;
			check_reset_state(); // Async reset, visible at once
		end
		reset = 1'b0;
		#1;
		check_reset_state();
	endtask

	task automatic load_program();
		MEM.clear_memories();
		foreach (prog[i])
			MEM.load_instr(i, prog[i]);
		apply_reset();
	endtask

	// Clock enable low, fetch address must sit on expect_pc
	task automatic pause_clock(int len, word_t expect_pc);
		word_t held_v0;
		clk_enable = 1'b0;
		#1;
		held_v0 = register_v0;
		repeat (len) begin
			check_bit("data_write", data_write, 1'b0);
			check_bit("data_read", data_read, 1'b0);
			@(posedge clk);
			#2;
			check_word("instr_address", instr_address, expect_pc);
			check_word("register_v0", register_v0, held_v0);
		end
		clk_enable = 1'b1;
		#1; // Let strobes follow the enable
	endtask

	// Runs until active falls, counting strobes between edges
	task automatic run_program(int budget, int pause_at, int pause_len);
		int cycles;
		cycles = 0;
		write_count = 0;
		read_count = 0;
		while (active && cycles < budget) begin
			if (cycles == pause_at)
				pause_clock(pause_len, RESET_VECTOR + word_t'(4 * pause_at)); // Straight-line only
			if (data_write) begin
				write_count++;
				last_write_addr = data_address;
				last_write_data = data_writedata;
			end
			if (data_read)
				read_count++;
			@(posedge clk);
			#2;
			cycles++;
		end
		if (active) begin
			other_errors++;
			$display("Program did not halt within %0d cycles at %0t", budget, $time);
		end
	endtask

	task automatic test_reset();
		prog.delete();
		prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h1234));
		prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
		load_program();
		run_program(RUN_BUDGET, -1, 0);
		check_word("register_v0", register_v0, 32'h00001234);
		apply_reset(); // Halted core with v0 set comes back clean
	endtask

	task automatic test_alu();
		word_t a;
		word_t b;
		word_t r;
		word_t simm;
		word_t zimm;
		word_t ins;
		word_t expected;
		logic [15:0] imm;
		logic [4:0] sh;
		for (int k = 0; k < ALU_CASES; k++) begin
			a = next_random();
			b = next_random();
			r = next_random();
			imm = r[15:0];
			sh = r[20:16];
			simm = {{16{imm[15]}}, imm};
			zimm = {16'h0000, imm};
			case (k)
				0: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_ADDU);
				1: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_SUBU);
				2: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_AND);
				3: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_OR);
				4: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_XOR);
				5: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_SLT);
				6: ins = rtype_word(5'd8, 5'd9, 5'd2, 5'd0, FN_SLTU);
				7: ins = rtype_word(5'd0, 5'd9, 5'd2, sh, FN_SLL);
				8: ins = rtype_word(5'd0, 5'd9, 5'd2, sh, FN_SRL);
				9: ins = rtype_word(5'd0, 5'd9, 5'd2, sh, FN_SRA);
				10: ins = itype_word(OP_ADDIU, 5'd8, 5'd2, imm);
				11: ins = itype_word(OP_ANDI, 5'd8, 5'd2, imm);
				12: ins = itype_word(OP_ORI, 5'd8, 5'd2, imm);
				13: ins = itype_word(OP_XORI, 5'd8, 5'd2, imm);
				14: ins = itype_word(OP_SLTI, 5'd8, 5'd2, imm);
				15: ins = itype_word(OP_SLTIU, 5'd8, 5'd2, imm);
				default: ins = itype_word(OP_LUI, 5'd0, 5'd2, imm);
			endcase
			case (k)
				0: expected = a + b;
				1: expected = a - b;
				2: expected = a & b;
				3: expected = a | b;
				4: expected = a ^ b;
				5: expected = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b}; // Sign decides
				6: expected = {31'd0, a < b};
				7: expected = b << sh;
				8: expected = b >> sh;
				9: expected = b[31] ? ~(~b >> sh) : b >> sh; // Ones shifted in
				10: expected = a + simm;
				11: expected = a & zimm;
				12: expected = a | zimm;
				13: expected = a ^ zimm;
				14: expected = (a[31] != simm[31]) ? {31'd0, a[31]} : {31'd0, a < simm};
				15: expected = {31'd0, a < simm}; // Sign-extended, compared unsigned
				default: expected = {imm, 16'h0000};
			endcase
			prog.delete();
			load_const(5'd8, a);
			load_const(5'd9, b);
			prog.push_back(ins);
			prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
			load_program();
			run_program(RUN_BUDGET, -1, 0);
			check_word($sformatf("register_v0 (ALU case %0d)", k), register_v0, expected);
		end
	endtask

	// SW at word 4, LW back into v0 at word 5
	task automatic build_load_store(word_t value);
		prog.delete();
		load_const(5'd8, DATA_BASE);
		load_const(5'd9, value);
		prog.push_back(itype_word(OP_SW, 5'd8, 5'd9, 16'h0008));
		prog.push_back(itype_word(OP_LW, 5'd8, 5'd2, 16'h0008));
		prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
	endtask

	task automatic check_strobe_counts();
		if (write_count != 1 || read_count != 1) begin
			other_errors++;
			$display("Saw %0d write and %0d read strobes, expected one of each",
				write_count, read_count);
		end
	endtask

	task automatic test_load_store();
		stored_value = next_random();
		build_load_store(stored_value);
		load_program();
		run_program(RUN_BUDGET, -1, 0);
		check_strobe_counts();
		check_word("data_address", last_write_addr, DATA_BASE + 32'd8);
		check_word("data_writedata", last_write_data, stored_value);
		check_word("register_v0", register_v0, stored_value);
	endtask

	// Each path adds its own bit to v0, skipped paths add high bits
	task automatic test_control_flow();
		prog.delete();
		prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd8, 16'd5));
		prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd9, 16'd5));
		prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd10, 16'd7));
		prog.push_back(itype_word(OP_BEQ, 5'd8, 5'd9, 16'd1)); // Taken
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0001));
		prog.push_back(itype_word(OP_BEQ, 5'd8, 5'd10, 16'd1)); // Not taken
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0002));
		prog.push_back(itype_word(OP_BNE, 5'd8, 5'd10, 16'd1)); // Taken
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0200));
		prog.push_back(itype_word(OP_BNE, 5'd8, 5'd9, 16'd1)); // Not taken
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0004));
		prog.push_back(jump_word(OP_J, 14));
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0400));
		prog.push_back(jump_word(OP_JAL, 18)); // $31 gets word 15
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0008));
		prog.push_back(rtype_word(5'd2, 5'd31, 5'd2, 5'd0, FN_ADDU)); // Fold in return address
		prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
		prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0010)); // Subroutine
		prog.push_back(rtype_word(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
		load_program();
		run_program(RUN_BUDGET, -1, 0);
		check_word("register_v0", register_v0, RESET_VECTOR + 32'd60 + 32'd31);
	endtask

	task automatic test_clock_enable();
		build_load_store(stored_value);
		load_program();
		run_program(RUN_BUDGET, 4, PAUSE_LEN); // Pause with SW on the bus
		check_strobe_counts();
		check_word("data_address", last_write_addr, DATA_BASE + 32'd8);
		check_word("register_v0", register_v0, stored_value);
	endtask

	task automatic test_halt();
		prog.delete();
		prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h0055));
		prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
		load_program();
		run_program(RUN_BUDGET, -1, 0);
		repeat (HALT_HOLD) begin
			check_bit("active", active, 1'b0);
			check_word("instr_address", instr_address, '0);
			check_word("register_v0", register_v0, 32'h00000055);
			check_bit("data_write", data_write, 1'b0);
			check_bit("data_read", data_read, 1'b0);
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		reset = 1'b1;
		clk_enable = 1'b0;
		rng_state = SEED;
		@(posedge clk);
		#2; // Drive off the rising edge
		test_reset();
		test_alu();
		test_load_store();
		test_control_flow();
		test_clock_enable();
		test_halt();
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/mips_pkg.sv
verilog/mips_control.sv
verilog/mips_pc.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_cpu_harvard.sv
bench/tb_mips_mem.sv
bench/tb_mips_cpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_mips_cpu
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
